// ==== Makefile ====
# Verilator build and run of the decode stage testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
VFLAGS    ?= --binary
TOP       ?= decode_stage_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= RESULT: PASS

SRCS := $(filter %.sv,$(shell cat $(FILELIST)))
HDRS := $(wildcard *.svh)
BIN  := $(OBJ_DIR)/$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source, a header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP)

# the log decides the result, the simulator's own exit status does not
run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== decode_stage.sv ====
`default_nettype none

// register-read part of the decode stage
// the decoder steers the register file and the hi/lo registers, and the
// two operands come out one cycle after the instruction goes in
module decode_stage (
	input  logic                   clk,
	input  logic                   rst_n,
	input  mips_isa_pkg::word_t    instr,
	input  mips_isa_pkg::word_t    pc_plus_4,
	input  logic                   wb_write,
	input  mips_isa_pkg::reg_idx_t wb_rd,
	input  mips_isa_pkg::word_t    wb_data,
	output mips_isa_pkg::word_t    read_data_1,
	output mips_isa_pkg::word_t    read_data_2,
	output mips_isa_pkg::word_t    a0,
	output mips_isa_pkg::word_t    v0
);

	mips_isa_pkg::reg_idx_t      rs;
	mips_isa_pkg::reg_idx_t      rt;
	mips_ctrl_pkg::operand_src_t operand_src;
	logic                        jal;
	mips_ctrl_pkg::hilo_wr_t     hilo_wr;
	mips_isa_pkg::word_t         rs_value;
	mips_isa_pkg::word_t         rt_value;
	mips_isa_pkg::word_t         hi;
	mips_isa_pkg::word_t         lo;

	instr_decoder decoder_i (
		.instr       (instr),
		.rs          (rs),
		.rt          (rt),
		.operand_src (operand_src),
		.jal         (jal),
		.hilo_wr     (hilo_wr)
	);

	register_file regfile_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.rs          (rs),
		.rt          (rt),
		.operand_src (operand_src),
		.jal         (jal),
		.pc_plus_4   (pc_plus_4),
		.wb_write    (wb_write),
		.wb_rd       (wb_rd),
		.wb_data     (wb_data),
		.hi          (hi),
		.lo          (lo),
		.rs_value    (rs_value),
		.rt_value    (rt_value),
		.read_data_1 (read_data_1),
		.read_data_2 (read_data_2),
		.a0          (a0),
		.v0          (v0)
	);

	// hi and lo feed back into the operand select of the register file
	hilo_unit hilo_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.hilo_wr  (hilo_wr),
		.rs_value (rs_value),
		.rt_value (rt_value),
		.hi       (hi),
		.lo       (lo)
	);

endmodule

`default_nettype wire

// ==== decode_stage_tb.sv ====
`default_nettype none

`include "mips_cfg.svh"

// table driven testbench for the register-read part of the decode stage
// each row is one instruction, its outputs are checked one edge later
module decode_stage_tb;

	timeunit 1ns;
	timeprecision 1ps;

	// function codes and opcodes as the instruction set defines them
	localparam logic [5:0] FUNCT_SYSCALL = 6'h0c;
	localparam logic [5:0] FUNCT_MFHI    = 6'h10;
	localparam logic [5:0] FUNCT_MTHI    = 6'h11;
	localparam logic [5:0] FUNCT_MFLO    = 6'h12;
	localparam logic [5:0] FUNCT_MTLO    = 6'h13;
	localparam logic [5:0] FUNCT_MULTU   = 6'h19;
	localparam logic [5:0] FUNCT_ADDU    = 6'h21;
	localparam logic [5:0] OPCODE_JAL    = 6'h03;
	localparam int         RESET_TIMEOUT = 20;

	// one row: stimulus first, then the outputs expected after the edge
	typedef struct packed {
		mips_isa_pkg::word_t    instr;
		mips_isa_pkg::word_t    pc_plus_4;
		logic                   wb_write;
		mips_isa_pkg::reg_idx_t wb_rd;
		mips_isa_pkg::word_t    wb_data;
		mips_isa_pkg::word_t    exp_rd1;
		mips_isa_pkg::word_t    exp_rd2;
		mips_isa_pkg::word_t    exp_a0;
		mips_isa_pkg::word_t    exp_v0;
	} row_t;

	logic                   clk;
	logic                   rst_n;
	mips_isa_pkg::word_t    instr;
	mips_isa_pkg::word_t    pc_plus_4;
	logic                   wb_write;
	mips_isa_pkg::reg_idx_t wb_rd;
	mips_isa_pkg::word_t    wb_data;
	mips_isa_pkg::word_t    read_data_1;
	mips_isa_pkg::word_t    read_data_2;
	mips_isa_pkg::word_t    a0;
	mips_isa_pkg::word_t    v0;

	row_t   rows[$];
	integer seed = 72533;
	int     errors = 0;
	int     timeouts = 0;

	tb_clock_gen clock_gen_i (
		.clk   (clk),
		.rst_n (rst_n)
	);

	decode_stage dut_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr       (instr),
		.pc_plus_4   (pc_plus_4),
		.wb_write    (wb_write),
		.wb_rd       (wb_rd),
		.wb_data     (wb_data),
		.read_data_1 (read_data_1),
		.read_data_2 (read_data_2),
		.a0          (a0),
		.v0          (v0)
	);

	// R-type word with rd and shift amount left at zero
	function automatic mips_isa_pkg::word_t encode_rtype(input logic [4:0] rs,
		input logic [4:0] rt, input logic [5:0] funct);
		return {6'h00, rs, rt, 5'd0, 5'd0, funct};
	endfunction

	// every row gets its own return address, one word apart
	function automatic mips_isa_pkg::word_t pc_of_row(input int row);
		return 32'h0040_0000 + (32'(row) << 2);
	endfunction

	task automatic add_row(input mips_isa_pkg::word_t instr_w, input logic wr,
		input logic [4:0] rd, input mips_isa_pkg::word_t data,
		input mips_isa_pkg::word_t e1, input mips_isa_pkg::word_t e2,
		input mips_isa_pkg::word_t ea0, input mips_isa_pkg::word_t ev0);
		row_t r;
		r = '{instr_w, pc_of_row(rows.size()), wr, rd, data, e1, e2, ea0, ev0};
		rows.push_back(r);
	endtask

	// the random writeback data is drawn first, then every expectation
	// is worked out from the register, hi/lo and write-through rules
	task automatic fill_table();
		mips_isa_pkg::word_t sp_init;
		mips_isa_pkg::word_t d_v0;
		mips_isa_pkg::word_t d_a0;
		mips_isa_pkg::word_t d_zero;
		mips_isa_pkg::word_t d_t0;
		mips_isa_pkg::word_t d_t1;
		logic [63:0]         prod;
		sp_init = `MIPS_STACK_TOP - 32'd4;
		d_v0    = $random(seed);
		d_a0    = $random(seed);
		d_zero  = $random(seed);
		d_t0    = $random(seed);
		d_t1    = $random(seed);
		prod    = 64'(d_t0) * 64'(d_t1);
		// row 0 reads sp straight out of reset
		add_row(encode_rtype(5'd29, 5'd0, FUNCT_ADDU), 1'b0, 5'd0, '0, sp_init, '0, '0, '0);
		// rows 1 and 2 read v0 and a0 while they are being written
		add_row(encode_rtype(5'd2, 5'd4, FUNCT_ADDU), 1'b1, 5'd2, d_v0, d_v0, '0, '0, d_v0);
		add_row(encode_rtype(5'd4, 5'd2, FUNCT_ADDU), 1'b1, 5'd4, d_a0, d_a0, d_v0, d_a0, d_v0);
		// a write to register 0 is lost, in the same cycle and later
		add_row(encode_rtype(5'd0, 5'd0, FUNCT_ADDU), 1'b1, 5'd0, d_zero, '0, '0, d_a0, d_v0);
		add_row(encode_rtype(5'd0, 5'd2, FUNCT_ADDU), 1'b0, 5'd0, '0, '0, d_v0, d_a0, d_v0);
		// jal together with a writeback to ra, the jal write has to win
		add_row({OPCODE_JAL, 26'h010_0008}, 1'b1, 5'd31, d_t0, pc_of_row(5), '0, d_a0, d_v0);
		add_row(encode_rtype(5'd31, 5'd29, FUNCT_ADDU), 1'b0, 5'd0, '0,
			pc_of_row(5), sp_init, d_a0, d_v0);
		add_row(encode_rtype(5'd0, 5'd0, FUNCT_SYSCALL), 1'b0, 5'd0, '0, d_v0, d_a0, d_a0, d_v0);
		// load t0 and t1, then move them into hi and lo
		add_row(encode_rtype(5'd8, 5'd0, FUNCT_ADDU), 1'b1, 5'd8, d_t0, d_t0, '0, d_a0, d_v0);
		add_row(encode_rtype(5'd8, 5'd0, FUNCT_MTHI), 1'b1, 5'd9, d_t1, d_t0, '0, d_a0, d_v0);
		add_row(encode_rtype(5'd9, 5'd0, FUNCT_MTLO), 1'b0, 5'd0, '0, d_t1, '0, d_a0, d_v0);
		add_row(encode_rtype(5'd0, 5'd0, FUNCT_MFHI), 1'b0, 5'd0, '0, d_t0, '0, d_a0, d_v0);
		add_row(encode_rtype(5'd0, 5'd0, FUNCT_MFLO), 1'b0, 5'd0, '0, d_t1, '0, d_a0, d_v0);
		// multu reads its operands like any R-type, the halves come back later
		add_row(encode_rtype(5'd8, 5'd9, FUNCT_MULTU), 1'b0, 5'd0, '0, d_t0, d_t1, d_a0, d_v0);
		add_row(encode_rtype(5'd0, 5'd0, FUNCT_MFHI), 1'b0, 5'd0, '0, prod[63:32], '0, d_a0, d_v0);
		add_row(encode_rtype(5'd0, 5'd0, FUNCT_MFLO), 1'b0, 5'd0, '0, prod[31:0], '0, d_a0, d_v0);
		// mthi of v0 replaces the product half in hi, and mfhi right behind it reads v0 back
		add_row(encode_rtype(5'd2, 5'd0, FUNCT_MTHI), 1'b0, 5'd0, '0, d_v0, '0, d_a0, d_v0);
		add_row(encode_rtype(5'd0, 5'd0, FUNCT_MFHI), 1'b0, 5'd0, '0, d_v0, '0, d_a0, d_v0);
	endtask

	task automatic check_outputs(input string label, input mips_isa_pkg::word_t e1,
		input mips_isa_pkg::word_t e2, input mips_isa_pkg::word_t ea0,
		input mips_isa_pkg::word_t ev0);
		if (read_data_1 !== e1) begin
			$display("Mismatch at %t: read_data_1 expected %h, actual %h (%s)",
				$time, e1, read_data_1, label);
			errors++;
		end
		if (read_data_2 !== e2) begin
			$display("Mismatch at %t: read_data_2 expected %h, actual %h (%s)",
				$time, e2, read_data_2, label);
			errors++;
		end
		if (a0 !== ea0) begin
			$display("Mismatch at %t: a0 expected %h, actual %h (%s)", $time, ea0, a0, label);
			errors++;
		end
		if (v0 !== ev0) begin
			$display("Mismatch at %t: v0 expected %h, actual %h (%s)", $time, ev0, v0, label);
			errors++;
		end
	endtask

	initial begin
		int wait_cycles;
		int i;
		$timeformat(-9, 0, " ns", 10);
		instr     = '0;
		pc_plus_4 = '0;
		wb_write  = 1'b0;
		wb_rd     = '0;
		wb_data   = '0;
		fill_table();

		wait_cycles = 0;
		while (rst_n !== 1'b1 && wait_cycles < RESET_TIMEOUT) begin
			@(posedge clk);
			wait_cycles++;
		end

		if (rst_n !== 1'b1) begin
			$display("reset was still asserted after %0d clock cycles", wait_cycles);
			timeouts++;
		end else begin
			@(negedge clk);
			check_outputs("after reset", '0, '0, '0, '0);
			// row i goes in at one edge and is checked on the falling edge
			// after the next one, while row i+1 is already applied
			for (i = 0; i <= rows.size(); i++) begin
				@(posedge clk);
				if (i < rows.size()) begin
					instr     <= rows[i].instr;
					pc_plus_4 <= rows[i].pc_plus_4;
					wb_write  <= rows[i].wb_write;
					wb_rd     <= rows[i].wb_rd;
					wb_data   <= rows[i].wb_data;
				end else begin
					instr    <= '0;
					wb_write <= 1'b0;
				end
				@(negedge clk);
				if (i > 0) begin
					check_outputs($sformatf("row %0d", i - 1), rows[i - 1].exp_rd1,
						rows[i - 1].exp_rd2, rows[i - 1].exp_a0, rows[i - 1].exp_v0);
				end
			end
		end

		$display("%0d rows, %0d errors, %0d timeouts", rows.size(), errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== hilo_unit.sv ====
`default_nettype none

// the hi and lo registers of the multiply unit
// written by mthi, mtlo and multu, read through the register file
module hilo_unit (
	input  logic                    clk,
	input  logic                    rst_n,
	input  mips_ctrl_pkg::hilo_wr_t hilo_wr,
	input  mips_isa_pkg::word_t     rs_value,
	input  mips_isa_pkg::word_t     rt_value,
	output mips_isa_pkg::word_t     hi,
	output mips_isa_pkg::word_t     lo
);

	mips_isa_pkg::word_t hi_q;
	mips_isa_pkg::word_t lo_q;
	mips_isa_pkg::word_t hi_next;
	mips_isa_pkg::word_t lo_next;
	logic [63:0]         product;

	// both operands are zero extended so the product is unsigned
	assign product = {32'b0, rs_value} * {32'b0, rt_value};

	always_comb begin
		hi_next = hi_q;
		lo_next = lo_q;
		case (hilo_wr)
			mips_ctrl_pkg::HILO_HI: hi_next = rs_value;
			mips_ctrl_pkg::HILO_LO: lo_next = rs_value;
			mips_ctrl_pkg::HILO_PRODUCT: begin
				// upper half of the product lands in hi
				hi_next = product[63:32];
				lo_next = product[31:0];
			end
			default: begin
				hi_next = hi_q;
				lo_next = lo_q;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hi_q <= '0;
			lo_q <= '0;
		end else begin
			hi_q <= hi_next;
			lo_q <= lo_next;
		end
	end

	// the outputs already carry a value that is being written this cycle,
	// so an mfhi or mflo right behind the write sees the new value
	assign hi = hi_next;
	assign lo = lo_next;

endmodule

`default_nettype wire

// ==== instr_decoder.sv ====
`default_nettype none

// combinational decode of one instruction word into the register
// numbers and control levels that the register read needs
module instr_decoder (
	input  mips_isa_pkg::word_t         instr,
	output mips_isa_pkg::reg_idx_t      rs,
	output mips_isa_pkg::reg_idx_t      rt,
	output mips_ctrl_pkg::operand_src_t operand_src,
	output logic                        jal,
	output mips_ctrl_pkg::hilo_wr_t     hilo_wr
);

	mips_isa_pkg::opcode_t opcode;
	mips_isa_pkg::funct_t  funct;

	// the rs and rt fields sit at the same place in R and I formats
	assign rs = instr[25:21];
	assign rt = instr[20:16];

	assign opcode = mips_isa_pkg::opcode_t'(instr[31:26]);
	assign funct  = mips_isa_pkg::funct_t'(instr[5:0]);

	always_comb begin
		// ordinary instructions read rs and rt and leave hi and lo alone
		operand_src = mips_ctrl_pkg::SRC_GPR;
		hilo_wr     = mips_ctrl_pkg::HILO_NONE;
		jal         = 1'b0;

		case (opcode)
			mips_isa_pkg::OP_SPECIAL: begin
				case (funct)
					mips_isa_pkg::FN_SYSCALL: begin
						// the service wants the call number and its argument
						operand_src = mips_ctrl_pkg::SRC_SYSCALL;
					end
					mips_isa_pkg::FN_MFHI: begin
						operand_src = mips_ctrl_pkg::SRC_HI;
					end
					mips_isa_pkg::FN_MFLO: begin
						operand_src = mips_ctrl_pkg::SRC_LO;
					end
					mips_isa_pkg::FN_MTHI: begin
						hilo_wr = mips_ctrl_pkg::HILO_HI;
					end
					mips_isa_pkg::FN_MTLO: begin
						hilo_wr = mips_ctrl_pkg::HILO_LO;
					end
					mips_isa_pkg::FN_MULTU: begin
						// multu still reads rs and rt, the product goes to hi and lo
						hilo_wr = mips_ctrl_pkg::HILO_PRODUCT;
					end
					default: begin
						// the ALU ops and unknown function codes keep the plain register read
						operand_src = mips_ctrl_pkg::SRC_GPR;
						hilo_wr     = mips_ctrl_pkg::HILO_NONE;
					end
				endcase
			end
			mips_isa_pkg::OP_JAL: begin
				// jal passes the return address on and writes it to ra
				operand_src = mips_ctrl_pkg::SRC_LINK;
				jal         = 1'b1;
			end
			default: begin
				// the immediate ALU ops read rs and rt like any other instruction
				operand_src = mips_ctrl_pkg::SRC_GPR;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== mips_cfg.svh ====
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// register numbers of the general registers that the decode stage
// treats in a special way

// register 0 always reads as zero and ignores writes
`define MIPS_REG_ZERO 5'd0

// syscall number and first syscall argument
`define MIPS_REG_V0 5'd2
`define MIPS_REG_A0 5'd4

// stack pointer, loaded at reset
`define MIPS_REG_SP 5'd29

// return address, written by jal
`define MIPS_REG_RA 5'd31

// highest address of the stack region
// sp starts one word below this address
`define MIPS_STACK_TOP 32'h7fff_f000

`endif

// ==== mips_ctrl_pkg.sv ====
`default_nettype none

// control types that steer the decode datapath
package mips_ctrl_pkg;

	// where the two registered operands come from
	// gpr     rs and rt values
	// link    return address and zero, for jal
	// hi, lo  the hi or lo register and zero, for mfhi and mflo
	// syscall the v0 and a0 registers
	typedef enum logic [2:0] {
		SRC_GPR     = 3'd0,
		SRC_LINK    = 3'd1,
		SRC_HI      = 3'd2,
		SRC_LO      = 3'd3,
		SRC_SYSCALL = 3'd4
	} operand_src_t;

	// what is written into hi and lo at the next edge
	// hi and lo take rs for mthi and mtlo
	// product writes both halves of the multu result
	typedef enum logic [1:0] {
		HILO_NONE    = 2'd0,
		HILO_HI      = 2'd1,
		HILO_LO      = 2'd2,
		HILO_PRODUCT = 2'd3
	} hilo_wr_t;

endpackage

`default_nettype wire

// ==== mips_isa_pkg.sv ====
`default_nettype none

// types that come straight from the instruction set
package mips_isa_pkg;

	// one data or instruction word
	typedef logic [31:0] word_t;

	// number of one of the 32 general registers
	typedef logic [4:0] reg_idx_t;

	// primary opcodes in bits 31:26 that the decoder knows
	// special selects the R-type group, where funct picks the operation
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_JAL     = 6'h03,
		OP_ADDI    = 6'h08,
		OP_ADDIU   = 6'h09,
		OP_SLTI    = 6'h0a,
		OP_SLTIU   = 6'h0b,
		OP_ANDI    = 6'h0c,
		OP_ORI     = 6'h0d,
		OP_XORI    = 6'h0e,
		OP_LUI     = 6'h0f
	} opcode_t;

	// R-type function codes in bits 5:0 that the decoder knows
	typedef enum logic [5:0] {
		FN_SLL     = 6'h00,
		FN_SYSCALL = 6'h0c,
		FN_MFHI    = 6'h10,
		FN_MTHI    = 6'h11,
		FN_MFLO    = 6'h12,
		FN_MTLO    = 6'h13,
		FN_MULTU   = 6'h19,
		FN_ADDU    = 6'h21,
		FN_SUBU    = 6'h23,
		FN_AND     = 6'h24,
		FN_OR      = 6'h25,
		FN_XOR     = 6'h26,
		FN_NOR     = 6'h27,
		FN_SLT     = 6'h2a,
		FN_SLTU    = 6'h2b
	} funct_t;

endpackage

`default_nettype wire

// ==== register_file.sv ====
`default_nettype none

`include "mips_cfg.svh"

// the 32 general registers with the writeback port, the jal write to ra
// and the two operand registers that feed the execute stage
module register_file (
	input  logic                        clk,
	input  logic                        rst_n,
	input  mips_isa_pkg::reg_idx_t      rs,
	input  mips_isa_pkg::reg_idx_t      rt,
	input  mips_ctrl_pkg::operand_src_t operand_src,
	input  logic                        jal,
	input  mips_isa_pkg::word_t         pc_plus_4,
	input  logic                        wb_write,
	input  mips_isa_pkg::reg_idx_t      wb_rd,
	input  mips_isa_pkg::word_t         wb_data,
	input  mips_isa_pkg::word_t         hi,
	input  mips_isa_pkg::word_t         lo,
	output mips_isa_pkg::word_t         rs_value,
	output mips_isa_pkg::word_t         rt_value,
	output mips_isa_pkg::word_t         read_data_1,
	output mips_isa_pkg::word_t         read_data_2,
	output mips_isa_pkg::word_t         a0,
	output mips_isa_pkg::word_t         v0
);

	mips_isa_pkg::word_t regs [32];
	mips_isa_pkg::word_t op_1_next;
	mips_isa_pkg::word_t op_2_next;

	// read one register as it will be after this edge
	// the jal write to ra is checked first because it beats the writeback
	function automatic mips_isa_pkg::word_t read_reg(input mips_isa_pkg::reg_idx_t idx);
		mips_isa_pkg::word_t value;
		if (idx == `MIPS_REG_ZERO) begin
			value = '0;
		end else if (jal && idx == `MIPS_REG_RA) begin
			value = pc_plus_4;
		end else if (wb_write && idx == wb_rd) begin
			value = wb_data;
		end else begin
			value = regs[idx];
		end
		return value;
	endfunction

	// combinational reads for the multiply unit
	always_comb begin
		rs_value = read_reg(rs);
		rt_value = read_reg(rt);
	end

	// pick the pair of operands that goes to execute
	always_comb begin
		case (operand_src)
			mips_ctrl_pkg::SRC_LINK: begin
				op_1_next = pc_plus_4;
				op_2_next = '0;
			end
			mips_ctrl_pkg::SRC_HI: begin
				op_1_next = hi;
				op_2_next = '0;
			end
			mips_ctrl_pkg::SRC_LO: begin
				op_1_next = lo;
				op_2_next = '0;
			end
			mips_ctrl_pkg::SRC_SYSCALL: begin
				op_1_next = read_reg(`MIPS_REG_V0);
				op_2_next = read_reg(`MIPS_REG_A0);
			end
			default: begin
				op_1_next = rs_value;
				op_2_next = rt_value;
			end
		endcase
	end

	// register array, sp is the only register with a non-zero reset value
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
			regs[`MIPS_REG_SP] <= `MIPS_STACK_TOP - 32'd4;
		end else begin
			// writes to register 0 never land
			if (wb_write && wb_rd != `MIPS_REG_ZERO) begin
				regs[wb_rd] <= wb_data;
			end
			// later assignment, so jal wins over a writeback to ra
			if (jal) begin
				regs[`MIPS_REG_RA] <= pc_plus_4;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			read_data_1 <= '0;
			read_data_2 <= '0;
		end else begin
			read_data_1 <= op_1_next;
			read_data_2 <= op_2_next;
		end
	end

	// the syscall service watches these two straight from the array
	assign a0 = regs[`MIPS_REG_A0];
	assign v0 = regs[`MIPS_REG_V0];

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`default_nettype none

// clock and reset for the decode stage testbench
// 40 ns period, reset held low for the first four rising edges
module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// released on an edge, so the flops still see reset at that edge
	initial begin
		rst_n = 1'b0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+.
mips_isa_pkg.sv
mips_ctrl_pkg.sv
instr_decoder.sv
hilo_unit.sv
register_file.sv
decode_stage.sv
tb_clock_gen.sv
decode_stage_tb.sv
